// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_decode_execute
FILELIST  ?= sources.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal

SIM_BIN := $(BUILD_DIR)/V$(TOP)
SOURCES := $(shell grep -v '^+' $(FILELIST))
HEADERS := $(wildcard rtl/*.svh)

.PHONY: all run clean

all: run

$(SIM_BIN): $(SOURCES) $(HEADERS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

# Pass only if the simulation printed the pass line
run: $(SIM_BIN)
	@out="$$(./$(SIM_BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "No errors"

clean:
	rm -rf $(BUILD_DIR)

// File: rtl/core_defines.svh
`ifndef CORE_DEFINES_SVH
`define CORE_DEFINES_SVH

// Datapath width in bits
`define XLEN 32

// Architectural integer registers, x0 included
`define NUM_REGS 32

// PC value held by the ID/EX register out of reset
`define RESET_PC 32'h0000_0000

`endif

// File: rtl/core_pkg.sv
`default_nettype none

`include "core_defines.svh"

package core_pkg;

	typedef logic [`XLEN-1:0] word_t;
	typedef logic [$clog2(`NUM_REGS)-1:0] reg_addr_t;

	////////////////////////////////////////////////////////////
	// Encodings
	////////////////////////////////////////////////////////////

	// RV32I major opcodes handled by this slice
	typedef enum logic [6:0] {
		OPC_LOAD   = 7'b000_0011,
		OPC_OP_IMM = 7'b001_0011,
		OPC_STORE  = 7'b010_0011,
		OPC_OP     = 7'b011_0011,
		OPC_LUI    = 7'b011_0111,
		OPC_BRANCH = 7'b110_0011
	} opcode_e;

	typedef enum logic [3:0] {
		ADD,
		SUB,
		AND,
		OR,
		XOR,
		SLL,
		SRL,
		SRA,
		SLT,
		SLTU,
		PASS_B
	} alu_op_e;

	typedef enum logic {RS1, PC} port_a_sel_e;
	typedef enum logic {RS2, IMM} port_b_sel_e;
	typedef enum logic {FWD_NONE, FWD_EX} fwd_sel_e;
	typedef enum logic [1:0] {BR_NONE, BR_EQ, BR_NE} branch_e;

	////////////////////////////////////////////////////////////
	// Pipeline bundles
	////////////////////////////////////////////////////////////

	// Size follows funct3[1:0]: byte, half, word
	typedef struct packed {
		logic       en;
		logic       rw;
		logic [1:0] size;
		logic       sign;
	} mem_ctrl_t;

	// All zero is a bubble
	typedef struct packed {
		alu_op_e     alu_op;
		port_a_sel_e port_a_sel;
		port_b_sel_e port_b_sel;
		logic        reg_w;
		branch_e     branch;
		mem_ctrl_t   mem;
	} ex_ctrl_t;

	typedef struct packed {
		word_t     pc;
		reg_addr_t rs1_addr;
		reg_addr_t rs2_addr;
		word_t     rs1_data;
		word_t     rs2_data;
		reg_addr_t rd_addr;
		word_t     imm;
		ex_ctrl_t  ctrl;
	} id_ex_t;

	typedef struct packed {
		logic      valid;
		word_t     result;
		word_t     store_data;
		reg_addr_t rd_addr;
		logic      reg_w;
		mem_ctrl_t mem;
	} ex_mem_t;

endpackage

`default_nettype wire

// File: rtl/decode_execute_top.sv
`timescale 1ns/1ps
`default_nettype none

module decode_execute_top (
	input  wire logic              clk,
	input  wire logic              arst_n,
	input  wire logic              instr_valid,
	input  wire logic [31:0]       instr,
	input  wire core_pkg::word_t   pc,
	input  wire logic              mem_busy,
	output logic                   stall,
	output logic                   redirect,
	output core_pkg::word_t        redirect_pc,
	output logic                   result_valid,
	output core_pkg::ex_mem_t      ex_mem
);

	import core_pkg::*;

	reg_addr_t rs1_addr;
	reg_addr_t rs2_addr;
	word_t     rs1_data;
	word_t     rs2_data;
	id_ex_t    id_bundle;
	id_ex_t    ex_bundle;
	logic      ex_valid;
	logic      flush;
	logic      branch_taken;
	fwd_sel_e  fwd_a;
	fwd_sel_e  fwd_b;

	assign redirect     = branch_taken;
	assign result_valid = ex_mem.valid;

	////////////////////////////////////////////////////////////
	// Decode
	////////////////////////////////////////////////////////////

	instr_decoder i_instr_decoder (
		.instr     (instr),
		.pc        (pc),
		.rs1_addr  (rs1_addr),
		.rs2_addr  (rs2_addr),
		.rs1_data  (rs1_data),
		.rs2_data  (rs2_data),
		.id_bundle (id_bundle)
	);

	// Write port is fed straight from EX/MEM
	register_file i_register_file (
		.clk      (clk),
		.arst_n   (arst_n),
		.rs1_addr (rs1_addr),
		.rs2_addr (rs2_addr),
		.rs1_data (rs1_data),
		.rs2_data (rs2_data),
		.wb       (ex_mem),
		.stall    (stall)
	);

	////////////////////////////////////////////////////////////
	// Execute
	////////////////////////////////////////////////////////////

	id_ex_register i_id_ex_register (
		.clk         (clk),
		.arst_n      (arst_n),
		.instr_valid (instr_valid),
		.stall       (stall),
		.flush       (flush),
		.id_bundle   (id_bundle),
		.ex_bundle   (ex_bundle),
		.ex_valid    (ex_valid)
	);

	execute_unit i_execute_unit (
		.clk          (clk),
		.arst_n       (arst_n),
		.ex_bundle    (ex_bundle),
		.ex_valid     (ex_valid),
		.stall        (stall),
		.fwd_a        (fwd_a),
		.fwd_b        (fwd_b),
		.branch_taken (branch_taken),
		.redirect_pc  (redirect_pc),
		.ex_mem       (ex_mem)
	);

	pipeline_control i_pipeline_control (
		.ex_bundle    (ex_bundle),
		.ex_valid     (ex_valid),
		.ex_mem       (ex_mem),
		.mem_busy     (mem_busy),
		.branch_taken (branch_taken),
		.stall        (stall),
		.flush        (flush),
		.fwd_a        (fwd_a),
		.fwd_b        (fwd_b)
	);

endmodule

`default_nettype wire

// File: rtl/execute_unit.sv
`timescale 1ns/1ps
`default_nettype none

`include "core_defines.svh"

module execute_unit (
	input  wire logic               clk,
	input  wire logic               arst_n,
	input  wire core_pkg::id_ex_t   ex_bundle,
	input  wire logic               ex_valid,
	input  wire logic               stall,
	input  wire core_pkg::fwd_sel_e fwd_a,
	input  wire core_pkg::fwd_sel_e fwd_b,
	output logic                    branch_taken,
	output core_pkg::word_t         redirect_pc,
	output core_pkg::ex_mem_t       ex_mem
);

	import core_pkg::*;

	localparam int SHAMT_W = $clog2(`XLEN);

	word_t              op_a;
	word_t              op_b;
	word_t              alu_a;
	word_t              alu_b;
	word_t              alu_y;
	logic [SHAMT_W-1:0] shamt;
	logic               operands_eq;
	ex_mem_t            ex_mem_q;

	////////////////////////////////////////////////////////////
	// Operand selection and ALU
	////////////////////////////////////////////////////////////

	assign op_a = (fwd_a == FWD_EX) ? ex_mem_q.result : ex_bundle.rs1_data;
	assign op_b = (fwd_b == FWD_EX) ? ex_mem_q.result : ex_bundle.rs2_data;

	assign alu_a = (ex_bundle.ctrl.port_a_sel == PC) ? ex_bundle.pc : op_a;
	assign alu_b = (ex_bundle.ctrl.port_b_sel == IMM) ? ex_bundle.imm : op_b;
	assign shamt = alu_b[SHAMT_W-1:0];

	always_comb begin
		case (ex_bundle.ctrl.alu_op)
			ADD:     alu_y = alu_a + alu_b;
			SUB:     alu_y = alu_a - alu_b;
			AND:     alu_y = alu_a & alu_b;
			OR:      alu_y = alu_a | alu_b;
			XOR:     alu_y = alu_a ^ alu_b;
			SLL:     alu_y = alu_a << shamt;
			SRL:     alu_y = alu_a >> shamt;
			SRA:     alu_y = word_t'($signed(alu_a) >>> shamt);
			SLT:     alu_y = word_t'($signed(alu_a) < $signed(alu_b));
			SLTU:    alu_y = word_t'(alu_a < alu_b);
			PASS_B:  alu_y = alu_b;
			default: alu_y = alu_a + alu_b;
		endcase
	end

	// Branches compare the forwarded register values, not the port muxes
	assign operands_eq = (op_a == op_b);
	assign redirect_pc = ex_bundle.pc + ex_bundle.imm;

	always_comb begin
		case (ex_bundle.ctrl.branch)
			BR_EQ:   branch_taken = ex_valid && operands_eq;
			BR_NE:   branch_taken = ex_valid && !operands_eq;
			default: branch_taken = 1'b0;
		endcase
	end

	////////////////////////////////////////////////////////////
	// EX/MEM register
	////////////////////////////////////////////////////////////

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			ex_mem_q <= '0;
		end else if (!stall) begin
			ex_mem_q.valid      <= ex_valid;
			ex_mem_q.result     <= alu_y;
			ex_mem_q.store_data <= op_b;
			ex_mem_q.rd_addr    <= ex_bundle.rd_addr;
			ex_mem_q.reg_w      <= ex_bundle.ctrl.reg_w;
			ex_mem_q.mem        <= ex_bundle.ctrl.mem;
		end
	end

	// Held entry is shown again once the memory stage is free
	always_comb begin
		ex_mem       = ex_mem_q;
		ex_mem.valid = ex_mem_q.valid && !stall;
	end

endmodule

`default_nettype wire

// File: rtl/id_ex_register.sv
`timescale 1ns/1ps
`default_nettype none

`include "core_defines.svh"

module id_ex_register (
	input  wire logic             clk,
	input  wire logic             arst_n,
	input  wire logic             instr_valid,
	input  wire logic             stall,
	input  wire logic             flush,
	input  wire core_pkg::id_ex_t id_bundle,
	output core_pkg::id_ex_t      ex_bundle,
	output logic                  ex_valid
);

	import core_pkg::*;

	////////////////////////////////////////////////////////////
	// Pipeline register
	////////////////////////////////////////////////////////////

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			ex_bundle    <= '0;
			ex_bundle.pc <= `RESET_PC;
			ex_valid     <= 1'b0;
		end else if (!stall) begin
			ex_bundle <= id_bundle;
			ex_valid  <= instr_valid && !flush;
			// Data still loads, only the controls turn into a bubble
			if (!instr_valid || flush) begin
				ex_bundle.ctrl <= '0;
			end
		end
	end

	// A flush during a stall would be lost, since the register holds
	a_no_flush_in_stall: assert property (@(posedge clk) disable iff (!arst_n)
		!(flush && stall));

endmodule

`default_nettype wire

// File: rtl/instr_decoder.sv
`timescale 1ns/1ps
`default_nettype none

module instr_decoder (
	input  wire logic [31:0]        instr,
	input  wire core_pkg::word_t    pc,
	output core_pkg::reg_addr_t     rs1_addr,
	output core_pkg::reg_addr_t     rs2_addr,
	input  wire core_pkg::word_t    rs1_data,
	input  wire core_pkg::word_t    rs2_data,
	output core_pkg::id_ex_t        id_bundle
);

	import core_pkg::*;

	opcode_e    opcode;
	logic [2:0] funct3;
	logic       funct7_b5;
	word_t      imm_i;
	word_t      imm_s;
	word_t      imm_b;
	word_t      imm_u;
	word_t      imm;
	ex_ctrl_t   ctrl;

	// funct3/funct7 to ALU operation, SUB only exists in register form
	function automatic alu_op_e funct_to_alu(input logic [2:0] f3, input logic f7_b5,
		input logic is_reg);
		alu_op_e op;
		case (f3)
			3'b000: op = (is_reg && f7_b5) ? SUB : ADD;
			3'b001: op = SLL;
			3'b010: op = SLT;
			3'b011: op = SLTU;
			3'b100: op = XOR;
			3'b101: op = f7_b5 ? SRA : SRL;
			3'b110: op = OR;
			default: op = AND;
		endcase
		return op;
	endfunction

	assign opcode    = opcode_e'(instr[6:0]);
	assign funct3    = instr[14:12];
	assign funct7_b5 = instr[30];
	assign rs1_addr  = instr[19:15];
	assign rs2_addr  = instr[24:20];

	assign imm_i = {{20{instr[31]}}, instr[31:20]};
	assign imm_s = {{20{instr[31]}}, instr[31:25], instr[11:7]};
	assign imm_b = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
	assign imm_u = {instr[31:12], 12'b0};

	always_comb begin
		ctrl = '0;
		imm  = imm_i;
		case (opcode)
			OPC_OP: begin
				ctrl.alu_op = funct_to_alu(funct3, funct7_b5, 1'b1);
				ctrl.reg_w  = 1'b1;
			end
			OPC_OP_IMM: begin
				// Shift amount sits in imm[4:0]
				ctrl.alu_op     = funct_to_alu(funct3, funct7_b5, 1'b0);
				ctrl.port_b_sel = IMM;
				ctrl.reg_w      = 1'b1;
			end
			OPC_LUI: begin
				ctrl.alu_op     = PASS_B;
				ctrl.port_b_sel = IMM;
				ctrl.reg_w      = 1'b1;
				imm             = imm_u;
			end
			OPC_LOAD: begin
				// Load data returns past this slice, so rd is not written here
				if (funct3 inside {3'b000, 3'b001, 3'b010, 3'b100, 3'b101}) begin
					ctrl.port_b_sel = IMM;
					ctrl.mem.en     = 1'b1;
					ctrl.mem.size   = funct3[1:0];
					ctrl.mem.sign   = !funct3[2];
				end
			end
			OPC_STORE: begin
				imm = imm_s;
				if (funct3 inside {3'b000, 3'b001, 3'b010}) begin
					ctrl.port_b_sel = IMM;
					ctrl.mem.en     = 1'b1;
					ctrl.mem.rw     = 1'b1;
					ctrl.mem.size   = funct3[1:0];
				end
			end
			OPC_BRANCH: begin
				imm = imm_b;
				if (funct3 == 3'b000) begin
					ctrl.branch = BR_EQ;
				end else if (funct3 == 3'b001) begin
					ctrl.branch = BR_NE;
				end
			end
			// Anything else goes down the pipe as a bubble
			default: ctrl = '0;
		endcase
	end

	assign id_bundle = '{
		pc:       pc,
		rs1_addr: rs1_addr,
		rs2_addr: rs2_addr,
		rs1_data: rs1_data,
		rs2_data: rs2_data,
		rd_addr:  instr[11:7],
		imm:      imm,
		ctrl:     ctrl
	};

endmodule

`default_nettype wire

// File: rtl/pipeline_control.sv
`timescale 1ns/1ps
`default_nettype none

module pipeline_control (
	input  wire core_pkg::id_ex_t  ex_bundle,
	input  wire logic              ex_valid,
	input  wire core_pkg::ex_mem_t ex_mem,
	input  wire logic              mem_busy,
	input  wire logic              branch_taken,
	output logic                   stall,
	output logic                   flush,
	output core_pkg::fwd_sel_e     fwd_a,
	output core_pkg::fwd_sel_e     fwd_b
);

	import core_pkg::*;

	logic ex_mem_writes;

	////////////////////////////////////////////////////////////
	// Forwarding
	////////////////////////////////////////////////////////////

	// A stalled EX/MEM entry still owes its writeback, so it stays a source
	assign ex_mem_writes = (ex_mem.valid || stall) && ex_mem.reg_w && (ex_mem.rd_addr != '0);

	assign fwd_a = (ex_valid && ex_mem_writes && (ex_mem.rd_addr == ex_bundle.rs1_addr)) ?
		FWD_EX : FWD_NONE;
	assign fwd_b = (ex_valid && ex_mem_writes && (ex_mem.rd_addr == ex_bundle.rs2_addr)) ?
		FWD_EX : FWD_NONE;

	////////////////////////////////////////////////////////////
	// Stall and flush
	////////////////////////////////////////////////////////////

	// Stall wins, a held branch flushes on the cycle it finally advances
	always_comb begin
		stall = mem_busy;
		flush = branch_taken && !stall;
	end

endmodule

`default_nettype wire

// File: rtl/register_file.sv
`timescale 1ns/1ps
`default_nettype none

`include "core_defines.svh"

module register_file (
	input  wire logic                clk,
	input  wire logic                arst_n,
	input  wire core_pkg::reg_addr_t rs1_addr,
	input  wire core_pkg::reg_addr_t rs2_addr,
	output core_pkg::word_t          rs1_data,
	output core_pkg::word_t          rs2_data,
	input  wire core_pkg::ex_mem_t   wb,
	input  wire logic                stall
);

	import core_pkg::*;

	word_t regs [`NUM_REGS];
	logic  wr_en;

	// x0 is never a write target, so its entry stays at the reset value
	assign wr_en = wb.valid && wb.reg_w && !stall && (wb.rd_addr != '0);

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			for (int i = 0; i < `NUM_REGS; i++) begin
				regs[i] <= '0;
			end
		end else if (wr_en) begin
			regs[wb.rd_addr] <= wb.result;
		end
	end

	// Write-through, the instruction two behind reads the value retiring now
	assign rs1_data = (wr_en && (wb.rd_addr == rs1_addr)) ? wb.result : regs[rs1_addr];
	assign rs2_data = (wr_en && (wb.rd_addr == rs2_addr)) ? wb.result : regs[rs2_addr];

	a_x0_reads_zero: assert property (@(posedge clk) disable iff (!arst_n)
		((rs1_addr != '0) || (rs1_data == '0)) && ((rs2_addr != '0) || (rs2_data == '0)));

endmodule

`default_nettype wire

// File: sources.f
+incdir+rtl
rtl/core_pkg.sv
rtl/instr_decoder.sv
rtl/register_file.sv
rtl/id_ex_register.sv
rtl/execute_unit.sv
rtl/pipeline_control.sv
rtl/decode_execute_top.sv
testbench/tb_decode_execute.sv

// File: testbench/tb_decode_execute.sv
`timescale 1ns/1ps
`default_nettype none

module tb_decode_execute;

	import core_pkg::*;

	localparam int NUM_INSTR      = 400;
	localparam int TIMEOUT_CYCLES = 4 * NUM_INSTR + 100;

	// RV32I major opcodes
	localparam logic [6:0] ENC_REG    = 7'b0110011;
	localparam logic [6:0] ENC_IMM    = 7'b0010011;
	localparam logic [6:0] ENC_LUI    = 7'b0110111;
	localparam logic [6:0] ENC_LOAD   = 7'b0000011;
	localparam logic [6:0] ENC_STORE  = 7'b0100011;
	localparam logic [6:0] ENC_BRANCH = 7'b1100011;

	typedef enum logic [2:0] {
		KIND_REG,
		KIND_IMM,
		KIND_LUI,
		KIND_LOAD,
		KIND_STORE,
		KIND_BRANCH
	} instr_kind_e;

	// One expected EX/MEM entry, mem packed as en, rw, size, sign
	typedef struct packed {
		instr_kind_e kind;
		logic [31:0] result;
		logic [31:0] store_data;
		logic [4:0]  rd_addr;
		logic        reg_w;
		logic [4:0]  mem;
		logic        chk_result;
		logic        chk_store;
	} expect_t;

	logic        clk;
	logic        arst_n;
	logic        instr_valid;
	logic [31:0] instr;
	logic [31:0] pc;
	logic        mem_busy;
	logic        stall;
	logic        redirect;
	logic [31:0] redirect_pc;
	logic        result_valid;
	ex_mem_t     ex_mem;

	integer      seed;
	int          errors;
	int          checks;
	int          cycle_count;
	int          instr_count;
	logic [31:0] cur_instr;
	logic [31:0] cur_pc;
	logic        pending_flush;
	logic [31:0] branch_target;
	logic [31:0] model_regs [32];
	expect_t     exp_q [$];

	decode_execute_top i_decode_execute_top (
		.clk          (clk),
		.arst_n       (arst_n),
		.instr_valid  (instr_valid),
		.instr        (instr),
		.pc           (pc),
		.mem_busy     (mem_busy),
		.stall        (stall),
		.redirect     (redirect),
		.redirect_pc  (redirect_pc),
		.result_valid (result_valid),
		.ex_mem       (ex_mem)
	);

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	////////////////////////////////////////////////////////////
	// Checking and naming
	////////////////////////////////////////////////////////////

	task automatic check_value(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		checks++;
		if (actual !== expected) begin
			errors++;
			$display("error %s: expected %h, actual %h at %0t", name, expected, actual, $time);
		end
	endtask

	function automatic string kind_name(input instr_kind_e kind);
		case (kind)
			KIND_REG:   return "alu reg";
			KIND_IMM:   return "alu imm";
			KIND_LUI:   return "lui";
			KIND_LOAD:  return "load";
			KIND_STORE: return "store";
			default:    return "branch";
		endcase
	endfunction

	////////////////////////////////////////////////////////////
	// ISA reference model
	////////////////////////////////////////////////////////////

	function automatic logic [31:0] alu_result(input logic [2:0] f3, input logic alt,
		input logic [31:0] a, input logic [31:0] b);
		logic signed [31:0] sa;
		logic signed [31:0] sr;
		sa = a;
		sr = sa >>> b[4:0];
		case (f3)
			3'd0:    return alt ? a - b : a + b;
			3'd1:    return a << b[4:0];
			3'd2:    return {31'b0, $signed(a) < $signed(b)};
			3'd3:    return {31'b0, a < b};
			3'd4:    return a ^ b;
			3'd5:    return alt ? sr : a >> b[4:0];
			3'd6:    return a | b;
			default: return a & b;
		endcase
	endfunction

	task automatic model_execute(input logic [31:0] word, input logic [31:0] at_pc,
		output expect_t e, output logic taken, output logic [31:0] target);
		logic [2:0]  f3;
		logic [4:0]  rd;
		logic [31:0] a;
		logic [31:0] b;
		logic [31:0] imm_i;
		logic [31:0] imm_s;
		logic [31:0] imm_b;
		f3     = word[14:12];
		rd     = word[11:7];
		a      = model_regs[word[19:15]];
		b      = model_regs[word[24:20]];
		imm_i  = {{20{word[31]}}, word[31:20]};
		imm_s  = {{20{word[31]}}, word[31:25], word[11:7]};
		imm_b  = {{20{word[31]}}, word[7], word[30:25], word[11:8], 1'b0};
		e      = '0;
		taken  = 1'b0;
		target = at_pc + imm_b;
		e.rd_addr = rd;
		case (word[6:0])
			ENC_REG: begin
				e.kind   = KIND_REG;
				e.result = alu_result(f3, word[30], a, b);
			end
			ENC_IMM: begin
				// Only SRAI uses bit 30 as a selector
				e.kind   = KIND_IMM;
				e.result = alu_result(f3, word[30] && (f3 == 3'd5), a, imm_i);
			end
			ENC_LUI: begin
				e.kind   = KIND_LUI;
				e.result = {word[31:12], 12'b0};
			end
			ENC_LOAD: begin
				e.kind   = KIND_LOAD;
				e.result = a + imm_i;
				e.mem    = {1'b1, 1'b0, f3[1:0], !f3[2]};
			end
			ENC_STORE: begin
				e.kind       = KIND_STORE;
				e.result     = a + imm_s;
				e.store_data = b;
				e.mem        = {1'b1, 1'b1, f3[1:0], 1'b0};
				e.chk_store  = 1'b1;
			end
			default: begin
				e.kind = KIND_BRANCH;
				taken  = (f3 == 3'd0) ? (a == b) : (a != b);
			end
		endcase
		e.reg_w      = e.kind inside {KIND_REG, KIND_IMM, KIND_LUI};
		e.chk_result = (e.kind != KIND_BRANCH);
		// Load data never returns here, so only ALU kinds update the model
		if (e.reg_w && rd != 5'd0) begin
			model_regs[rd] = e.result;
		end
	endtask

	////////////////////////////////////////////////////////////
	// Stimulus
	////////////////////////////////////////////////////////////

	// Registers x0..x7 only, so dependences are frequent
	task automatic make_instr(output logic [31:0] word);
		logic [3:0]  pick;
		logic [4:0]  rd;
		logic [4:0]  rs1;
		logic [4:0]  rs2;
		logic [2:0]  f3;
		logic [11:0] imm12;
		logic [12:0] imm13;
		pick  = 4'($random(seed));
		rd    = {2'b0, 3'($random(seed))};
		rs1   = {2'b0, 3'($random(seed))};
		rs2   = {2'b0, 3'($random(seed))};
		f3    = 3'($random(seed));
		imm12 = 12'($random(seed));
		if (pick <= 4'd4) begin
			word = {1'b0, imm12[0] && (f3 == 3'd0 || f3 == 3'd5), 5'b0, rs2, rs1, f3, rd, ENC_REG};
		end else if (pick <= 4'd8) begin
			if (f3 == 3'd1) begin
				imm12 = {7'b0, imm12[4:0]};
			end else if (f3 == 3'd5) begin
				imm12 = {1'b0, imm12[10], 5'b0, imm12[4:0]};
			end
			word = {imm12, rs1, f3, rd, ENC_IMM};
		end else if (pick == 4'd9) begin
			word = {20'($random(seed)), rd, ENC_LUI};
		end else if (pick <= 4'd11) begin
			if (f3[1:0] == 2'b11) begin
				f3 = 3'd2;
			end
			if (f3 == 3'd6) begin
				f3 = 3'd4;
			end
			word = {imm12, rs1, f3, rd, ENC_LOAD};
		end else if (pick <= 4'd13) begin
			f3 = (f3[1:0] == 2'b11) ? 3'd2 : {1'b0, f3[1:0]};
			word = {imm12[11:5], rs2, rs1, f3, imm12[4:0], ENC_STORE};
		end else begin
			imm13 = {imm12, 1'b0};
			if (pick[0]) begin
				rs2 = rs1;
			end
			word = {imm13[12], imm13[10:5], rs2, rs1, 2'b0, f3[0], imm13[4:1], imm13[11],
				ENC_BRANCH};
		end
	endtask

	// Check at the falling edge, predict the next rising edge, drive after it
	task automatic run_cycle(input logic feeding);
		logic        consumed;
		logic        flush_now;
		logic        taken;
		logic [31:0] target;
		expect_t     e;
		string       name;
		@(negedge clk);
		check_value("stall", 32'(mem_busy), 32'(stall));
		check_value("redirect", 32'(pending_flush), 32'(redirect));
		if (pending_flush) begin
			check_value("redirect pc", branch_target, redirect_pc);
		end
		if (mem_busy) begin
			check_value("result_valid in stall", 32'd0, 32'(result_valid));
		end
		if (result_valid) begin
			if (exp_q.size() == 0) begin
				errors++;
				$display("Result appeared at %0t with no instruction outstanding", $time);
			end else begin
				e    = exp_q.pop_front();
				name = kind_name(e.kind);
				check_value({name, " reg_w"}, 32'(e.reg_w), 32'(ex_mem.reg_w));
				check_value({name, " mem ctrl"}, 32'(e.mem), 32'(ex_mem.mem));
				if (e.chk_result) begin
					check_value({name, " result"}, e.result, ex_mem.result);
				end
				if (e.reg_w) begin
					check_value({name, " rd"}, 32'(e.rd_addr), 32'(ex_mem.rd_addr));
				end
				if (e.chk_store) begin
					check_value({name, " store data"}, e.store_data, ex_mem.store_data);
				end
			end
		end
		consumed = 1'b0;
		if (!mem_busy) begin
			flush_now     = pending_flush;
			pending_flush = 1'b0;
			if (instr_valid) begin
				consumed = 1'b1;
				// Instruction behind a taken branch is dropped
				if (!flush_now) begin
					model_execute(instr, pc, e, taken, target);
					exp_q.push_back(e);
					pending_flush = taken;
					branch_target = target;
				end
			end
		end
		@(posedge clk);
		#2;
		if (consumed) begin
			instr_count++;
			cur_pc = cur_pc + 32'd4;
			make_instr(cur_instr);
		end
		mem_busy = feeding && (3'($random(seed)) < 3'd2);
		if (!instr_valid || consumed) begin
			if (feeding && instr_count < NUM_INSTR && 3'($random(seed)) != 3'd0) begin
				instr_valid = 1'b1;
				instr       = cur_instr;
			end else begin
				instr_valid = 1'b0;
				instr       = $random(seed);
			end
			pc = cur_pc;
		end
	endtask

	////////////////////////////////////////////////////////////
	// Main sequence and timeout
	////////////////////////////////////////////////////////////

	initial begin
		seed          = 32'h03e4_980e;
		arst_n        = 1'b0;
		instr_valid   = 1'b0;
		instr         = 32'h0000_0013;
		pc            = '0;
		mem_busy      = 1'b0;
		errors        = 0;
		checks        = 0;
		instr_count   = 0;
		cur_pc        = 32'h0000_0100;
		pending_flush = 1'b0;
		branch_target = '0;
		for (int i = 0; i < 32; i++) begin
			model_regs[i] = '0;
		end
		repeat (4) @(posedge clk);
		#2;
		arst_n = 1'b1;
		// Idle cycles straight after reset must stay quiet
		repeat (3) run_cycle(1'b0);
		make_instr(cur_instr);
		while (instr_count < NUM_INSTR) begin
			run_cycle(1'b1);
		end
		while (exp_q.size() != 0 || pending_flush) begin
			run_cycle(1'b0);
		end
		repeat (4) run_cycle(1'b0);
		$display("Checks: %0d, errors: %0d", checks, errors);
		if (errors == 0) begin
			$display("No errors");
		end else begin
			$display("Errors found");
		end
		$finish;
	end

	initial begin
		cycle_count = 0;
		while (cycle_count < TIMEOUT_CYCLES) begin
			@(posedge clk);
			cycle_count++;
		end
		$display("Timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
		$display("Checks: %0d, errors: %0d", checks, errors);
		$display("Errors found");
		$finish;
	end

endmodule

`default_nettype wire
